/* sim.f */
design/sensor_pkg.sv
design/sensor_interface.sv
design/sensor_config_regs.sv
design/sensor_alarm.sv
design/sensor_hub_top.sv
verif/sensor_interface_asserts.sv
verif/sensor_hub_tb.sv

/* Makefile */
# Verilator flow for the sensor hub testbench.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= sensor_hub_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= ALL TESTS PASSED
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides pass or fail, not the exit status of the run.
sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/sensor_hub_tb.sv */
// sensor hub testbench with LFSR sensor data, a scripted register program and a watchdog.
`timescale 1ns/1ps
`default_nettype none

module sensor_hub_tb;

  localparam int clk_freq      = 1000;
  localparam int sample_freq   = 100;
  localparam int period_cycles = clk_freq / sample_freq + 1;  // 11 cycles per sample.
  localparam int reset_cycles  = 10;
  localparam int watchdog_ns   = (reset_cycles + 40 * period_cycles) * 10;
  localparam logic [7:0] mid_limit = 8'h80;

  logic                          clk;
  logic                          rst_n;
  sensor_pkg::sensor_sample_t    sensor_in;
  logic                          cfg_we;
  sensor_pkg::cfg_addr_e         cfg_addr;
  logic [sensor_pkg::data_w-1:0] cfg_wdata;
  logic [sensor_pkg::data_w-1:0] cfg_rdata;
  logic                          sample_ready;
  sensor_pkg::sensor_sample_t    sample_out;
  logic                          irq;
  logic [31:0]                   lfsr;
  logic [7:0]                    ctrl_seen;
  logic [7:0]                    limit_seen;

  sensor_hub_top #(
    .clk_freq    (clk_freq),
    .sample_freq (sample_freq)
  ) u_sensor_hub_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .sensor_in    (sensor_in),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .sample_ready (sample_ready),
    .sample_out   (sample_out),
    .irq          (irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // random source and helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hd000_0001;  // galois feedback taps.
    end
    return state >> 1;
  endfunction

  task automatic random_byte(output logic [7:0] value);
    value = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  // one write cycle, then one idle cycle on the same address.
  task automatic write_reg(input sensor_pkg::cfg_addr_e addr, input logic [7:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_samples(input int count);
    int seen;
    seen = 0;
    while (seen < count) begin
      @(negedge clk);
      if (sample_ready) seen++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) @(posedge clk);
    #1;
  endtask

  // new sensor levels every cycle.
  initial begin
    logic [7:0] t_val;
    logic [7:0] p_val;
    logic [7:0] h_val;
    lfsr      = 32'h753e;
    sensor_in = '0;
    forever begin
      @(posedge clk);
      #1;
      random_byte(t_val);
      random_byte(p_val);
      random_byte(h_val);
      sensor_in = '{temp: t_val, pressure: p_val, humidity: h_val};
    end
  end

  // ------------------------------------------------------------
  // failure hook and watchdog
  // ------------------------------------------------------------
  initial begin
    wait (u_sensor_hub_top.u_asserts.fail_count != 0);
    $display("Assertion check failed at time %0t", $time);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping after the first assertion failure");
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: the register program did not finish within 40 sample periods");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------
  // register program
  // ------------------------------------------------------------
  initial begin
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = sensor_pkg::ADDR_CTRL;
    cfg_wdata = 8'h00;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    write_reg(sensor_pkg::ADDR_CTRL, 8'h01);
    write_reg(sensor_pkg::ADDR_TEMP_HI, mid_limit);
    write_reg(sensor_pkg::ADDR_PRES_HI, mid_limit);
    write_reg(sensor_pkg::ADDR_HUM_HI, mid_limit);
    write_reg(sensor_pkg::ADDR_MASK, 8'h07);
    cfg_addr = sensor_pkg::ADDR_TEMP;
    wait_samples(2);
    cfg_addr = sensor_pkg::ADDR_PRES;
    wait_samples(2);
    cfg_addr = sensor_pkg::ADDR_HUM;
    wait_samples(2);
    write_reg(sensor_pkg::ADDR_STATUS, 8'h07);
    // time the next clear pulse onto a ready cycle.
    wait_samples(1);
    idle_cycles(period_cycles - 2);
    write_reg(sensor_pkg::ADDR_STATUS, 8'h07);
    write_reg(sensor_pkg::ADDR_MASK, 8'h03);  // temp masked off.
    cfg_addr = sensor_pkg::ADDR_STATUS;
    wait_samples(3);
    write_reg(sensor_pkg::ADDR_CTRL, 8'h00);
    idle_cycles(2 * period_cycles);
    write_reg(sensor_pkg::ADDR_CTRL, 8'h01);
    wait_samples(3);
    cfg_addr = sensor_pkg::ADDR_CTRL;
    @(negedge clk);
    ctrl_seen = cfg_rdata;
    cfg_addr = sensor_pkg::ADDR_PRES_HI;
    @(negedge clk);
    limit_seen = cfg_rdata;
    if (ctrl_seen != 8'h01 || limit_seen != mid_limit) begin
      $display("ERROR at time %0t: readback ctrl %h (expected 01), pres_hi %h (expected %h)",
               $time, ctrl_seen, limit_seen, mid_limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "final readback mismatch");
    end else if (u_sensor_hub_top.u_asserts.fail_count != 0) begin
      $display("SOME TESTS FAILED");
      $fatal(1, "assertion failures were counted");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verif/sensor_interface_asserts.sv */
// sensor hub checker for sample pacing, capture and hold, alarm flags, irq and register readback.
`timescale 1ns/1ps
`default_nettype none

module sensor_interface_asserts #(
  parameter int clk_freq    = 100000000,
  parameter int sample_freq = 100
) (
  input wire logic                         clk,
  input wire logic                         rst_n,
  input wire logic                         enable,
  input wire sensor_pkg::sensor_sample_t   sensor_in,
  input wire logic                         sample_ready,
  input wire sensor_pkg::sensor_sample_t   sample_out,
  input wire sensor_pkg::sensor_limits_t   limits,
  input wire sensor_pkg::alarm_flags_t     mask,
  input wire sensor_pkg::alarm_flags_t     alarm_clear,
  input wire sensor_pkg::alarm_flags_t     alarm_flags,
  input wire logic                         irq,
  input wire logic                         cfg_we,
  input wire sensor_pkg::cfg_addr_e         cfg_addr,
  input wire logic [sensor_pkg::data_w-1:0] cfg_wdata,
  input wire logic [sensor_pkg::data_w-1:0] cfg_rdata
);

  localparam logic [31:0] last_count = 32'(clk_freq / sample_freq);

  int                       fail_count = 0;  // polled by the testbench.
  logic [31:0]              ref_count;
  sensor_pkg::alarm_flags_t over;
  logic                     status_wr;

  // bits of each address that hold written data.
  function automatic logic [7:0] rw_bits(input sensor_pkg::cfg_addr_e addr);
    logic [7:0] bits;
    case (addr)
      sensor_pkg::ADDR_CTRL:    bits = 8'h01;
      sensor_pkg::ADDR_TEMP_HI: bits = 8'hff;
      sensor_pkg::ADDR_PRES_HI: bits = 8'hff;
      sensor_pkg::ADDR_HUM_HI:  bits = 8'hff;
      sensor_pkg::ADDR_MASK:    bits = 8'h07;
      default:                  bits = 8'h00;
    endcase
    return bits;
  endfunction

  // what a non-writable address shows.
  function automatic logic [7:0] live_view(input sensor_pkg::cfg_addr_e addr,
                                           input sensor_pkg::sensor_sample_t s,
                                           input sensor_pkg::alarm_flags_t f);
    logic [7:0] view;
    case (addr)
      sensor_pkg::ADDR_TEMP:   view = s.temp;
      sensor_pkg::ADDR_PRES:   view = s.pressure;
      sensor_pkg::ADDR_HUM:    view = s.humidity;
      sensor_pkg::ADDR_STATUS: view = {5'b00000, f};
      default:                 view = 8'h00;
    endcase
    return view;
  endfunction

  // ------------------------------------------------------------
  // expected period and compare results
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_count <= '0;
    end else if (!enable || ref_count == last_count) begin
      ref_count <= '0;
    end else begin
      ref_count <= ref_count + 32'd1;
    end
  end

  assign over.temp     = sample_out.temp > limits.temp_hi;
  assign over.pressure = sample_out.pressure > limits.pressure_hi;
  assign over.humidity = sample_out.humidity > limits.humidity_hi;
  assign status_wr     = cfg_we && (cfg_addr == sensor_pkg::ADDR_STATUS);

  // ------------------------------------------------------------
  // properties
  // ------------------------------------------------------------
  a_pace: assert property (@(posedge clk) disable iff (!rst_n)
    sample_ready == (enable && ref_count == last_count))
    else begin fail_count++; $error("sample_ready out of step with the sample period"); end

  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    $past(sample_ready) |-> !sample_ready)
    else begin fail_count++; $error("sample_ready longer than one cycle"); end

  a_capture: assert property (@(posedge clk) disable iff (!rst_n)
    sample_ready |-> sample_out == sensor_in)
    else begin fail_count++; $error("sample_out differs from sensor_in in ready cycle"); end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !sample_ready |-> sample_out == $past(sample_out))
    else begin fail_count++; $error("sample_out changed outside a ready cycle"); end

  a_flag_set: assert property (@(posedge clk) disable iff (!rst_n)
    $past(sample_ready) |->
      alarm_flags == (($past(alarm_flags) & ~$past(alarm_clear)) | $past(over)))
    else begin fail_count++; $error("alarm flags wrong after a sample"); end

  a_flag_keep: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(sample_ready) |-> alarm_flags == ($past(alarm_flags) & ~$past(alarm_clear)))
    else begin fail_count++; $error("alarm flags changed without sample or clear"); end

  a_clear_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    $past(status_wr) |-> alarm_clear == sensor_pkg::alarm_flags_t'($past(cfg_wdata[2:0])))
    else begin fail_count++; $error("status write gave a wrong clear pulse"); end

  a_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(status_wr) |-> alarm_clear == '0)
    else begin fail_count++; $error("clear pulse without a status write"); end

  a_irq: assert property (@(posedge clk) disable iff (!rst_n)
    irq == $past(|(alarm_flags & mask)))
    else begin fail_count++; $error("irq does not follow masked flags"); end

  a_rw_readback: assert property (@(posedge clk) disable iff (!rst_n)
    $past(cfg_we) && (cfg_addr == $past(cfg_addr)) && (rw_bits(cfg_addr) != 8'h00) |->
      cfg_rdata == ($past(cfg_wdata) & rw_bits(cfg_addr)))
    else begin fail_count++; $error("written register read back wrong"); end

  a_live_readback: assert property (@(posedge clk) disable iff (!rst_n)
    (rw_bits(cfg_addr) == 8'h00) |-> cfg_rdata == live_view(cfg_addr, sample_out, alarm_flags))
    else begin fail_count++; $error("sample or status readback wrong"); end

  // reset values are seen one cycle after a clock edge with reset held.
  a_reset: assert property (@(posedge clk)
    !rst_n |=> !sample_ready && !irq && !enable && (&limits) && (alarm_flags == '0))
    else begin fail_count++; $error("wrong values under reset"); end

endmodule

bind sensor_hub_top sensor_interface_asserts #(
  .clk_freq    (clk_freq),
  .sample_freq (sample_freq)
) u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .enable       (enable),
  .sensor_in    (sensor_in),
  .sample_ready (sample_ready),
  .sample_out   (sample_out),
  .limits       (limits),
  .mask         (mask),
  .alarm_clear  (alarm_clear),
  .alarm_flags  (alarm_flags),
  .irq          (irq),
  .cfg_we       (cfg_we),
  .cfg_addr     (cfg_addr),
  .cfg_wdata    (cfg_wdata),
  .cfg_rdata    (cfg_rdata)
);

`default_nettype wire

/* design/sensor_hub_top.sv */
// environmental sensor hub top that ties the register block, sample pacer and alarm logic.
`timescale 1ns/1ps
`default_nettype none

module sensor_hub_top #(
  parameter int clk_freq    = 100000000,
  parameter int sample_freq = 100
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire sensor_pkg::sensor_sample_t   sensor_in,
  input  wire logic                         cfg_we,
  input  wire sensor_pkg::cfg_addr_e         cfg_addr,
  input  wire logic [sensor_pkg::data_w-1:0] cfg_wdata,
  output logic [sensor_pkg::data_w-1:0]     cfg_rdata,
  output logic                              sample_ready,
  output sensor_pkg::sensor_sample_t        sample_out,
  output logic                              irq
);

  // ------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------
  logic                       enable;
  sensor_pkg::sensor_limits_t limits;
  sensor_pkg::alarm_flags_t   mask;
  sensor_pkg::alarm_flags_t   alarm_clear;
  sensor_pkg::alarm_flags_t   alarm_flags;

  sensor_config_regs u_sensor_config_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .sample_out  (sample_out),
    .alarm_flags (alarm_flags),
    .cfg_rdata   (cfg_rdata),
    .enable      (enable),
    .limits      (limits),
    .mask        (mask),
    .alarm_clear (alarm_clear)
  );

  // only the pacer needs the rate parameters.
  sensor_interface #(
    .clk_freq    (clk_freq),
    .sample_freq (sample_freq)
  ) u_sensor_interface (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (enable),
    .sensor_in    (sensor_in),
    .sample_ready (sample_ready),
    .sample_out   (sample_out)
  );

  sensor_alarm u_sensor_alarm (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_ready (sample_ready),
    .sample_out   (sample_out),
    .limits       (limits),
    .mask         (mask),
    .alarm_clear  (alarm_clear),
    .alarm_flags  (alarm_flags),
    .irq          (irq)
  );

endmodule

`default_nettype wire

/* design/sensor_alarm.sv */
// alarm block that compares samples to upper limits, keeps sticky flags and drives irq.
`timescale 1ns/1ps
`default_nettype none

module sensor_alarm (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       sample_ready,
  input  wire sensor_pkg::sensor_sample_t sample_out,
  input  wire sensor_pkg::sensor_limits_t limits,
  input  wire sensor_pkg::alarm_flags_t   mask,
  input  wire sensor_pkg::alarm_flags_t   alarm_clear,
  output sensor_pkg::alarm_flags_t        alarm_flags,
  output logic                            irq
);

  sensor_pkg::alarm_flags_t over_limit;
  sensor_pkg::alarm_flags_t set_flags;
  sensor_pkg::alarm_flags_t masked;

  // ------------------------------------------------------------
  // over-limit compare
  // ------------------------------------------------------------
  always_comb begin
    over_limit.temp     = sample_out.temp     > limits.temp_hi;
    over_limit.pressure = sample_out.pressure > limits.pressure_hi;
    over_limit.humidity = sample_out.humidity > limits.humidity_hi;
  end

  // only a ready cycle can raise a flag.
  assign set_flags = sample_ready ? over_limit : '0;

  // ------------------------------------------------------------
  // sticky flags
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alarm_flags <= '0;
    end else begin
      // set wins over a clear in the same cycle.
      alarm_flags <= (alarm_flags & ~alarm_clear) | set_flags;
    end
  end

  // ------------------------------------------------------------
  // interrupt
  // ------------------------------------------------------------
  assign masked = alarm_flags & mask;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= |masked;  // level, one cycle behind the flags.
    end
  end

endmodule

`default_nettype wire

/* design/sensor_config_regs.sv */
// host register block for enable, limits and mask, with status clear and sample readback.
`timescale 1ns/1ps
`default_nettype none

module sensor_config_regs (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire logic                        cfg_we,
  input  wire sensor_pkg::cfg_addr_e        cfg_addr,
  input  wire logic [sensor_pkg::data_w-1:0] cfg_wdata,
  input  wire sensor_pkg::sensor_sample_t   sample_out,
  input  wire sensor_pkg::alarm_flags_t     alarm_flags,
  output logic [sensor_pkg::data_w-1:0]    cfg_rdata,
  output logic                             enable,
  output sensor_pkg::sensor_limits_t       limits,
  output sensor_pkg::alarm_flags_t         mask,
  output sensor_pkg::alarm_flags_t         alarm_clear
);

  sensor_pkg::alarm_flags_t wdata_flags;

  // wdata bits mapped onto the per-channel flag layout.
  assign wdata_flags.temp     = cfg_wdata[sensor_pkg::ALARM_TEMP];
  assign wdata_flags.pressure = cfg_wdata[sensor_pkg::ALARM_PRES];
  assign wdata_flags.humidity = cfg_wdata[sensor_pkg::ALARM_HUM];

  // ------------------------------------------------------------
  // control and status
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable      <= 1'b0;
      mask        <= '0;
      alarm_clear <= '0;
    end else begin
      alarm_clear <= '0;  // one-cycle pulse.
      if (cfg_we) begin
        case (cfg_addr)
          sensor_pkg::ADDR_CTRL:   enable      <= cfg_wdata[0];
          sensor_pkg::ADDR_MASK:   mask        <= wdata_flags;
          sensor_pkg::ADDR_STATUS: alarm_clear <= wdata_flags;
          default: ;
        endcase
      end
    end
  end

  // ------------------------------------------------------------
  // upper limits
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      limits <= '1;  // nothing alarms until programmed.
    end else if (cfg_we) begin
      case (cfg_addr)
        sensor_pkg::ADDR_TEMP_HI: limits.temp_hi     <= cfg_wdata;
        sensor_pkg::ADDR_PRES_HI: limits.pressure_hi <= cfg_wdata;
        sensor_pkg::ADDR_HUM_HI:  limits.humidity_hi <= cfg_wdata;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // readback
  // ------------------------------------------------------------
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      sensor_pkg::ADDR_CTRL:    cfg_rdata[0] = enable;
      sensor_pkg::ADDR_TEMP_HI: cfg_rdata    = limits.temp_hi;
      sensor_pkg::ADDR_PRES_HI: cfg_rdata    = limits.pressure_hi;
      sensor_pkg::ADDR_HUM_HI:  cfg_rdata    = limits.humidity_hi;
      sensor_pkg::ADDR_MASK: begin
        cfg_rdata[sensor_pkg::ALARM_TEMP] = mask.temp;
        cfg_rdata[sensor_pkg::ALARM_PRES] = mask.pressure;
        cfg_rdata[sensor_pkg::ALARM_HUM]  = mask.humidity;
      end
      sensor_pkg::ADDR_STATUS: begin
        cfg_rdata[sensor_pkg::ALARM_TEMP] = alarm_flags.temp;
        cfg_rdata[sensor_pkg::ALARM_PRES] = alarm_flags.pressure;
        cfg_rdata[sensor_pkg::ALARM_HUM]  = alarm_flags.humidity;
      end
      sensor_pkg::ADDR_TEMP:    cfg_rdata = sample_out.temp;
      sensor_pkg::ADDR_PRES:    cfg_rdata = sample_out.pressure;
      sensor_pkg::ADDR_HUM:     cfg_rdata = sample_out.humidity;
      default:                  cfg_rdata = '0;  // unmapped reads as zero.
    endcase
  end

endmodule

`default_nettype wire

/* design/sensor_interface.sv */
// sensor sample pacer that strobes all three channels together and holds the last sample.
`timescale 1ns/1ps
`default_nettype none

module sensor_interface #(
  parameter int clk_freq    = 100000000,
  parameter int sample_freq = 100
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      enable,
  input  wire sensor_pkg::sensor_sample_t sensor_in,
  output logic                           sample_ready,
  output sensor_pkg::sensor_sample_t     sample_out
);

  // counter wraps after this value, so one period is last_count+1 cycles.
  localparam logic [31:0] last_count = 32'(clk_freq / sample_freq);

  logic [31:0]                sample_counter;
  logic                       at_last;
  sensor_pkg::sensor_sample_t hold_q;

  // ------------------------------------------------------------
  // sample rate counter
  // ------------------------------------------------------------
  assign at_last = (sample_counter == last_count);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_counter <= '0;
    end else if (!enable) begin
      sample_counter <= '0;  // parked while disabled.
    end else if (at_last) begin
      sample_counter <= '0;
    end else begin
      sample_counter <= sample_counter + 32'd1;
    end
  end

  // common strobe for the three channels.
  assign sample_ready = enable && at_last;

  // ------------------------------------------------------------
  // capture and hold
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_q <= '0;
    end else if (sample_ready) begin
      hold_q <= sensor_in;  // latch at end of ready cycle.
    end
  end

  // raw inputs pass straight through during the ready cycle.
  always_comb begin
    if (sample_ready) begin
      sample_out = sensor_in;
    end else begin
      sample_out = hold_q;
    end
  end

endmodule

`default_nettype wire

/* design/sensor_pkg.sv */
// sensor hub shared types covering channel samples, upper limits, alarm flags and register map.
`default_nettype none

package sensor_pkg;

  localparam int data_w = 8;  // bits per sensor channel.

  // ------------------------------------------------------------
  // channel data and thresholds
  // ------------------------------------------------------------
  typedef struct packed {
    logic [data_w-1:0] temp;
    logic [data_w-1:0] pressure;
    logic [data_w-1:0] humidity;
  } sensor_sample_t;

  typedef struct packed {
    logic [data_w-1:0] temp_hi;
    logic [data_w-1:0] pressure_hi;
    logic [data_w-1:0] humidity_hi;
  } sensor_limits_t;

  // one bit per channel; also used for the mask and the clear vector.
  typedef struct packed {
    logic temp;
    logic pressure;
    logic humidity;
  } alarm_flags_t;

  // bit positions of the flags in the mask and status registers.
  typedef enum logic [1:0] {
    ALARM_HUM  = 2'd0,
    ALARM_PRES = 2'd1,
    ALARM_TEMP = 2'd2
  } alarm_bit_e;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    ADDR_CTRL    = 4'h0,  // bit 0 enables sampling.
    ADDR_TEMP_HI = 4'h1,
    ADDR_PRES_HI = 4'h2,
    ADDR_HUM_HI  = 4'h3,
    ADDR_MASK    = 4'h4,
    ADDR_STATUS  = 4'h5,  // write one to clear.
    ADDR_TEMP    = 4'h6,  // read only.
    ADDR_PRES    = 4'h7,  // read only.
    ADDR_HUM     = 4'h8   // read only.
  } cfg_addr_e;

endpackage

`default_nettype wire
